/* hdl/rv_core_pkg.sv */
`default_nettype none

package rv_core_pkg;

    // --------------------------------------------------
    // widths
    localparam int XLEN = 32;

    typedef logic [XLEN-1:0] xlen_t;
    typedef logic [31:0]     inst_t;
    typedef logic [4:0]      reg_addr_t;

    // --------------------------------------------------
    // major opcodes kept in this core
    localparam logic [6:0] OPC_OP     = 7'b0110011;
    localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
    localparam logic [6:0] OPC_LUI    = 7'b0110111;

    // alu operation, PASS_B serves lui
    typedef enum logic [3:0] {
        ADD    = 4'd0,
        SUB    = 4'd1,
        SLL    = 4'd2,
        SLT    = 4'd3,
        SLTU   = 4'd4,
        XOR    = 4'd5,
        SRL    = 4'd6,
        SRA    = 4'd7,
        OR     = 4'd8,
        AND    = 4'd9,
        PASS_B = 4'd10
    } alu_op_e;

    // --------------------------------------------------
    // stage records
    typedef struct packed {
        logic      valid;
        logic      we;
        logic      illegal;
        reg_addr_t rd;
        alu_op_e   alu_op;
        xlen_t     op_a;
        xlen_t     op_b;
    } dec_exe_t;

    typedef struct packed {
        logic      valid;
        logic      we;
        logic      illegal;
        reg_addr_t rd;
        xlen_t     result;
    } exe_res_t;

    typedef struct packed {
        reg_addr_t rd;
        xlen_t     data;
        logic      we;
        logic      illegal;
    } retire_t;

    // sent back from a later stage to decode
    typedef struct packed {
        logic      valid;
        logic      we;
        reg_addr_t rd;
        xlen_t     data;
    } fwd_t;

endpackage

`default_nettype wire

/* hdl/rv_regfile.sv */
`default_nettype none

module rv_regfile
    import rv_core_pkg::*;
#(
    parameter int NUM_REGS = 32
) (
    input  logic      clk,
    input  logic      rst,
    input  logic      we_i,
    input  reg_addr_t waddr_i,
    input  xlen_t     wdata_i,
    input  reg_addr_t raddr_a_i,
    input  reg_addr_t raddr_b_i,
    output xlen_t     rdata_a_o,
    output xlen_t     rdata_b_o
);

    xlen_t regs [NUM_REGS];

    // x0 and unimplemented indices read as zero
    function automatic xlen_t read_port(reg_addr_t addr, xlen_t arr [NUM_REGS]);
        xlen_t val;
        val = '0;
        if ((addr != '0) && (int'(addr) < NUM_REGS)) begin
            val = arr[addr];
        end
        return val;
    endfunction

    assign rdata_a_o = read_port(raddr_a_i, regs);
    assign rdata_b_o = read_port(raddr_b_i, regs);

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (we_i && (waddr_i != '0) && (int'(waddr_i) < NUM_REGS)) begin
            regs[waddr_i] <= wdata_i;
        end
    end

    // decode flags out-of-range rd as illegal, so no write reaches here
    a_waddr_in_range: assert property (@(posedge clk) disable iff (rst)
        we_i |-> (int'(waddr_i) < NUM_REGS));

endmodule

`default_nettype wire

/* hdl/rv_decode.sv */
`default_nettype none

module rv_decode
    import rv_core_pkg::*;
#(
    parameter int NUM_REGS = 32
) (
    input  logic      clk,
    input  logic      rst,
    input  logic      inst_valid_i,
    input  inst_t     inst_i,
    output reg_addr_t rs1_addr_o,
    output reg_addr_t rs2_addr_o,
    input  xlen_t     rs1_data_i,
    input  xlen_t     rs2_data_i,
    input  fwd_t      fwd_exe_i,
    input  fwd_t      fwd_res_i,
    output dec_exe_t  dec_exe_o
);

    // execute bundle wins over result, result wins over the register file
    function automatic xlen_t pick_src(reg_addr_t idx, xlen_t rf_val, fwd_t exe, fwd_t res);
        xlen_t val;
        val = rf_val;
        if (idx == '0) begin
            val = '0;
        end else if (exe.valid && exe.we && (exe.rd == idx)) begin
            val = exe.data;
        end else if (res.valid && res.we && (res.rd == idx)) begin
            val = res.data;
        end
        return val;
    endfunction

    function automatic alu_op_e op_from_funct3(logic [2:0] funct3, logic alt);
        alu_op_e op;
        unique case (funct3)
            3'b000: op = alt ? SUB : ADD;
            3'b001: op = SLL;
            3'b010: op = SLT;
            3'b011: op = SLTU;
            3'b100: op = XOR;
            3'b101: op = alt ? SRA : SRL;
            3'b110: op = OR;
            default: op = AND;
        endcase
        return op;
    endfunction

    // --------------------------------------------------
    // field extraction
    logic [6:0] opcode;
    logic [2:0] funct3;
    logic [6:0] funct7;
    reg_addr_t  rd;
    reg_addr_t  rs1;
    reg_addr_t  rs2;
    xlen_t      imm_i;
    xlen_t      imm_u;

    assign opcode = inst_i[6:0];
    assign rd     = inst_i[11:7];
    assign funct3 = inst_i[14:12];
    assign rs1    = inst_i[19:15];
    assign rs2    = inst_i[24:20];
    assign funct7 = inst_i[31:25];
    assign imm_i  = {{(XLEN-12){inst_i[31]}}, inst_i[31:20]};
    assign imm_u  = {inst_i[31:12], 12'b0};

    assign rs1_addr_o = rs1;
    assign rs2_addr_o = rs2;

    // --------------------------------------------------
    // control decode
    alu_op_e alu_op;
    logic    legal;
    logic    use_rs1;
    logic    use_rs2;
    logic    use_imm;
    logic    range_ok;
    xlen_t   imm;

    always_comb begin
        alu_op  = ADD;
        legal   = 1'b1;
        use_rs1 = 1'b0;
        use_rs2 = 1'b0;
        use_imm = 1'b0;
        imm     = imm_i;
        unique case (opcode)
            OPC_OP: begin
                use_rs1 = 1'b1;
                use_rs2 = 1'b1;
                alu_op  = op_from_funct3(funct3, funct7[5]);
                // only add/sub and srl/sra have an alternate encoding
                if ((funct3 == 3'b000) || (funct3 == 3'b101)) begin
                    legal = (funct7 == 7'b0000000) || (funct7 == 7'b0100000);
                end else begin
                    legal = (funct7 == 7'b0000000);
                end
            end
            OPC_OP_IMM: begin
                use_rs1 = 1'b1;
                use_imm = 1'b1;
                alu_op  = op_from_funct3(funct3, (funct3 == 3'b101) && funct7[5]);
                if (funct3 == 3'b001) begin
                    legal = (funct7 == 7'b0000000);
                end else if (funct3 == 3'b101) begin
                    legal = (funct7 == 7'b0000000) || (funct7 == 7'b0100000);
                end
            end
            OPC_LUI: begin
                use_imm = 1'b1;
                imm     = imm_u;
                alu_op  = PASS_B;
            end
            default: begin
                legal = 1'b0;
            end
        endcase
    end

    // indices beyond the implemented register count
    assign range_ok = !(use_rs1 && (int'(rs1) >= NUM_REGS))
                   && !(use_rs2 && (int'(rs2) >= NUM_REGS))
                   && (int'(rd) < NUM_REGS);

    // --------------------------------------------------
    // operands and stage register
    dec_exe_t dec_next;

    always_comb begin
        dec_next.valid   = inst_valid_i;
        dec_next.illegal = !(legal && range_ok);
        dec_next.we      = legal && range_ok;
        dec_next.rd      = rd;
        dec_next.alu_op  = alu_op;
        dec_next.op_a    = pick_src(rs1, rs1_data_i, fwd_exe_i, fwd_res_i);
        dec_next.op_b    = use_imm ? imm : pick_src(rs2, rs2_data_i, fwd_exe_i, fwd_res_i);
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            dec_exe_o <= '0;
        end else begin
            dec_exe_o <= dec_next;
        end
    end

endmodule

`default_nettype wire

/* hdl/rv_execute.sv */
`default_nettype none

module rv_execute
    import rv_core_pkg::*;
(
    input  logic     clk,
    input  logic     rst,
    input  dec_exe_t dec_exe_i,
    output fwd_t     fwd_exe_o,
    output exe_res_t exe_res_o
);

    // --------------------------------------------------
    // alu
    xlen_t      op_a;
    xlen_t      op_b;
    logic [4:0] shamt;
    xlen_t      alu_res;
    xlen_t      result;

    assign op_a  = dec_exe_i.op_a;
    assign op_b  = dec_exe_i.op_b;
    assign shamt = op_b[4:0];

    always_comb begin
        unique case (dec_exe_i.alu_op)
            ADD:     alu_res = op_a + op_b;
            SUB:     alu_res = op_a - op_b;
            SLL:     alu_res = op_a << shamt;
            SLT:     alu_res = xlen_t'($signed(op_a) < $signed(op_b));
            SLTU:    alu_res = xlen_t'(op_a < op_b);
            XOR:     alu_res = op_a ^ op_b;
            SRL:     alu_res = op_a >> shamt;
            SRA:     alu_res = xlen_t'($signed(op_a) >>> shamt);
            OR:      alu_res = op_a | op_b;
            AND:     alu_res = op_a & op_b;
            PASS_B:  alu_res = op_b;
            default: alu_res = '0;
        endcase
    end

    // illegal instructions carry a zero result
    assign result = dec_exe_i.illegal ? '0 : alu_res;

    // distance-one forwarding straight from the alu
    assign fwd_exe_o = '{
        valid: dec_exe_i.valid,
        we:    dec_exe_i.we,
        rd:    dec_exe_i.rd,
        data:  result
    };

    // --------------------------------------------------
    // execute/result stage register
    always_ff @(posedge clk) begin
        if (rst) begin
            exe_res_o <= '0;
        end else begin
            exe_res_o <= '{
                valid:   dec_exe_i.valid,
                we:      dec_exe_i.we,
                illegal: dec_exe_i.illegal,
                rd:      dec_exe_i.rd,
                result:  result
            };
        end
    end

    a_alu_op_known: assert property (@(posedge clk) disable iff (rst)
        (dec_exe_i.valid && !dec_exe_i.illegal) |->
            (dec_exe_i.alu_op inside {ADD, SUB, SLL, SLT, SLTU, XOR, SRL, SRA, OR, AND,
                                      PASS_B}));

endmodule

`default_nettype wire

/* hdl/rv_result.sv */
`default_nettype none

module rv_result
    import rv_core_pkg::*;
(
    input  logic      clk,
    input  logic      rst,
    input  exe_res_t  exe_res_i,
    output logic      rf_we_o,
    output reg_addr_t rf_waddr_o,
    output xlen_t     rf_wdata_o,
    output fwd_t      fwd_res_o,
    output logic      retire_valid_o,
    output retire_t   retire_o
);

    logic wr_en;

    // no write for x0 or for illegal instructions
    assign wr_en = exe_res_i.valid && exe_res_i.we && !exe_res_i.illegal
                && (exe_res_i.rd != '0);

    assign rf_we_o    = wr_en;
    assign rf_waddr_o = exe_res_i.rd;
    assign rf_wdata_o = exe_res_i.result;

    // distance-two forwarding, same value the register file gets next edge
    assign fwd_res_o = '{
        valid: exe_res_i.valid,
        we:    wr_en,
        rd:    exe_res_i.rd,
        data:  exe_res_i.result
    };

    assign retire_valid_o = exe_res_i.valid;
    assign retire_o = '{
        rd:      exe_res_i.rd,
        data:    exe_res_i.result,
        we:      wr_en,
        illegal: exe_res_i.illegal
    };

    a_no_x0_write: assert property (@(posedge clk) disable iff (rst)
        rf_we_o |-> (rf_waddr_o != '0));

endmodule

`default_nettype wire

/* hdl/rv_alu_core.sv */
`default_nettype none

module rv_alu_core
    import rv_core_pkg::*;
#(
    parameter int NUM_REGS = 32
) (
    input  logic    clk,
    input  logic    rst,
    input  logic    inst_valid_i,
    input  inst_t   inst_i,
    output logic    retire_valid_o,
    output retire_t retire_o
);

    // --------------------------------------------------
    // inter-stage wires
    reg_addr_t rs1_addr;
    reg_addr_t rs2_addr;
    xlen_t     rs1_data;
    xlen_t     rs2_data;
    fwd_t      fwd_exe;
    fwd_t      fwd_res;
    dec_exe_t  dec_exe;
    exe_res_t  exe_res;
    logic      rf_we;
    reg_addr_t rf_waddr;
    xlen_t     rf_wdata;

    rv_decode #(
        .NUM_REGS (NUM_REGS)
    ) u_rv_decode (
        .clk          (clk),
        .rst          (rst),
        .inst_valid_i (inst_valid_i),
        .inst_i       (inst_i),
        .rs1_addr_o   (rs1_addr),
        .rs2_addr_o   (rs2_addr),
        .rs1_data_i   (rs1_data),
        .rs2_data_i   (rs2_data),
        .fwd_exe_i    (fwd_exe),
        .fwd_res_i    (fwd_res),
        .dec_exe_o    (dec_exe)
    );

    rv_execute u_rv_execute (
        .clk       (clk),
        .rst       (rst),
        .dec_exe_i (dec_exe),
        .fwd_exe_o (fwd_exe),
        .exe_res_o (exe_res)
    );

    rv_result u_rv_result (
        .clk            (clk),
        .rst            (rst),
        .exe_res_i      (exe_res),
        .rf_we_o        (rf_we),
        .rf_waddr_o     (rf_waddr),
        .rf_wdata_o     (rf_wdata),
        .fwd_res_o      (fwd_res),
        .retire_valid_o (retire_valid_o),
        .retire_o       (retire_o)
    );

    rv_regfile #(
        .NUM_REGS (NUM_REGS)
    ) u_rv_regfile (
        .clk       (clk),
        .rst       (rst),
        .we_i      (rf_we),
        .waddr_i   (rf_waddr),
        .wdata_i   (rf_wdata),
        .raddr_a_i (rs1_addr),
        .raddr_b_i (rs2_addr),
        .rdata_a_o (rs1_data),
        .rdata_b_o (rs2_data)
    );

endmodule

`default_nettype wire

/* verif/rv_ref_model.svh */
`ifndef RV_REF_MODEL_SVH
`define RV_REF_MODEL_SVH

// --------------------------------------------------
// architectural model, one instruction at a time in issue order

// expected retire record plus the edge that sampled the instruction
typedef struct packed {
    retire_t rec;
    int      sample_cycle;
} expect_t;

xlen_t   model_regs [32];
expect_t expect_q [$];

function automatic void model_reset();
    for (int i = 0; i < 32; i++) begin
        model_regs[i] = '0;
    end
    expect_q.delete();
endfunction

function automatic xlen_t model_read(reg_addr_t idx);
    if (idx == 5'd0) begin
        return '0;
    end
    return model_regs[idx];
endfunction

// sign fill built from the top bit
function automatic xlen_t shift_right_arith(xlen_t a, logic [4:0] sh);
    xlen_t fill;
    fill = a[31] ? ~(32'hffff_ffff >> sh) : '0;
    return (a >> sh) | fill;
endfunction

// signed compare through the sign bits
function automatic logic less_signed(xlen_t a, xlen_t b);
    if (a[31] != b[31]) begin
        return a[31];
    end
    return a < b;
endfunction

function automatic void model_issue(inst_t inst, int sample_cycle);
    logic [6:0] opc;
    logic [2:0] f3;
    logic [6:0] f7;
    reg_addr_t  rd;
    xlen_t      a;
    xlen_t      b;
    xlen_t      val;
    logic       ok;
    expect_t    e;
    opc = inst[6:0];
    f3  = inst[14:12];
    f7  = inst[31:25];
    rd  = inst[11:7];
    a   = model_read(inst[19:15]);
    b   = '0;
    val = '0;
    ok  = 1'b0;
    if (opc == OPC_LUI) begin
        val = {inst[31:12], 12'h000};
        ok  = 1'b1;
    end else if ((opc == OPC_OP) || (opc == OPC_OP_IMM)) begin
        if (opc == OPC_OP) begin
            b = model_read(inst[24:20]);
        end else begin
            b = {{20{inst[31]}}, inst[31:20]};
        end
        case (f3)
            3'b000: val = ((opc == OPC_OP) && f7[5]) ? a - b : a + b;
            3'b001: val = a << b[4:0];
            3'b010: val = {31'b0, less_signed(a, b)};
            3'b011: val = {31'b0, a < b};
            3'b100: val = a ^ b;
            3'b101: val = f7[5] ? shift_right_arith(a, b[4:0]) : a >> b[4:0];
            3'b110: val = a | b;
            default: val = a & b;
        endcase
        // funct7 rules of RV32I, only sub and sra use 0x20
        if (opc == OPC_OP) begin
            ok = (f7 == 7'h00) || ((f7 == 7'h20) && ((f3 == 3'b000) || (f3 == 3'b101)));
        end else if (f3 == 3'b001) begin
            ok = (f7 == 7'h00);
        end else if (f3 == 3'b101) begin
            ok = (f7 == 7'h00) || (f7 == 7'h20);
        end else begin
            ok = 1'b1;
        end
    end
    e.rec.rd         = rd;
    e.rec.data       = ok ? val : '0;
    e.rec.we         = ok && (rd != 5'd0);
    e.rec.illegal    = !ok;
    e.sample_cycle   = sample_cycle;
    expect_q.push_back(e);
    if (e.rec.we) begin
        model_regs[rd] = val;
    end
endfunction

`endif

/* verif/tb_rv_alu_core.sv */
`default_nettype none

module tb_rv_alu_core
    import rv_core_pkg::*;
();

    localparam int NUM_INSTS      = 2000;
    localparam int VALID_PCT      = 70;
    localparam int RETIRE_LATENCY = 2;
    localparam int MAX_CYCLES     = 10000;
    localparam int DRAIN_TIMEOUT  = 50;

    logic    clk = 1'b0;
    logic    rst;
    logic    inst_valid;
    inst_t   inst_word;
    logic    retire_valid;
    retire_t retire;

    int value_errors = 0;
    int latency_errors = 0;
    int other_errors = 0;
    int issued = 0;
    int retired = 0;
    int cycle = 0;

    `include "rv_ref_model.svh"

    always #20 clk = ~clk;

    rv_alu_core #(
        .NUM_REGS (32)
    ) u_rv_alu_core (
        .clk            (clk),
        .rst            (rst),
        .inst_valid_i   (inst_valid),
        .inst_i         (inst_word),
        .retire_valid_o (retire_valid),
        .retire_o       (retire)
    );

    // --------------------------------------------------
    // stimulus generation

    // mostly x0..x3 so that dependencies are dense
    function automatic reg_addr_t pick_reg();
        if ($urandom_range(0, 99) < 75) begin
            return reg_addr_t'($urandom_range(0, 3));
        end
        return reg_addr_t'($urandom_range(0, 31));
    endfunction

    function automatic logic [11:0] pick_imm12();
        if ($urandom_range(0, 99) < 30) begin
            case ($urandom_range(0, 4))
                0: return 12'h001;
                1: return 12'h7ff;
                2: return 12'h800;
                3: return 12'hfff;
                default: return 12'h000;
            endcase
        end
        return 12'($urandom());
    endfunction

    function automatic logic [19:0] pick_upper();
        if ($urandom_range(0, 99) < 30) begin
            case ($urandom_range(0, 2))
                0: return 20'h80000;
                1: return 20'h7ffff;
                default: return 20'hfffff;
            endcase
        end
        return 20'($urandom());
    endfunction

    function automatic inst_t make_inst();
        int unsigned kind;
        logic [2:0]  f3;
        logic [6:0]  f7;
        logic [11:0] imm12;
        inst_t       inst;
        kind = $urandom_range(0, 99);
        f3   = 3'($urandom_range(0, 7));
        if (kind < 45) begin
            f7 = 7'h00;
            if (((f3 == 3'b000) || (f3 == 3'b101)) && ($urandom_range(0, 1) == 1)) begin
                f7 = 7'h20;
            end
            if ($urandom_range(0, 99) < 5) begin
                f7 = 7'($urandom());
            end
            inst = {f7, pick_reg(), pick_reg(), f3, pick_reg(), OPC_OP};
        end else if (kind < 80) begin
            imm12 = pick_imm12();
            // shifts carry their funct7 in the top immediate bits
            if ((f3 == 3'b001) || (f3 == 3'b101)) begin
                imm12[11:5] = ((f3 == 3'b101) && ($urandom_range(0, 1) == 1)) ? 7'h20 : 7'h00;
                if ($urandom_range(0, 99) < 5) begin
                    imm12[11:5] = 7'($urandom());
                end
            end
            inst = {imm12, pick_reg(), f3, pick_reg(), OPC_OP_IMM};
        end else if (kind < 90) begin
            inst = {pick_upper(), pick_reg(), OPC_LUI};
        end else begin
            inst = inst_t'($urandom());
            if ($urandom_range(0, 1) == 0) begin
                // low bits 00 never match a kept opcode
                inst[6:0] = {5'($urandom()), 2'b00};
            end else begin
                case ($urandom_range(0, 3))
                    0: inst[6:0] = 7'b0000011;
                    1: inst[6:0] = 7'b0100011;
                    2: inst[6:0] = 7'b1100011;
                    default: inst[6:0] = 7'b0010111;
                endcase
            end
        end
        return inst;
    endfunction

    // one retire record as readable fields
    function automatic string format_retire(retire_t r);
        return $sformatf("rd=%0d data=%08h we=%0b ill=%0b", r.rd, r.data, r.we, r.illegal);
    endfunction

    // --------------------------------------------------
    // retire checking, called once per rising edge
    task automatic check_retire(int now);
        expect_t head;
        if (retire_valid) begin
            retired++;
            assert (expect_q.size() > 0) else begin
                other_errors++;
                $display("retire at time %0t with no instruction outstanding", $time);
            end
            if (expect_q.size() > 0) begin
                head = expect_q.pop_front();
                assert (retire == head.rec) else begin
                    value_errors++;
                    $display("** Error at %0t: got %s, expected %s",
                             $time, format_retire(retire), format_retire(head.rec));
                end
                // retire went high one edge before this check
                assert ((now - 1 - head.sample_cycle) == RETIRE_LATENCY) else begin
                    latency_errors++;
                    $display("** Error at %0t: retire %0d cycles after sample, expected %0d",
                             $time, now - 1 - head.sample_cycle, RETIRE_LATENCY);
                end
            end
        end
    endtask

    // --------------------------------------------------
    // main sequence
    initial begin
        int          waited;
        inst_t       next_inst;
        void'($urandom(32'h2af8));
        model_reset();
        rst        <= 1'b1;
        inst_valid <= 1'b0;
        inst_word  <= '0;
        repeat (2) @(posedge clk);
        rst <= 1'b0;
        assert (!retire_valid) else begin
            other_errors++;
            $display("retire_valid_o is high after reset");
        end

        while ((issued < NUM_INSTS) && (cycle < MAX_CYCLES)) begin
            @(posedge clk);
            cycle++;
            check_retire(cycle);
            if ($urandom_range(0, 99) < VALID_PCT) begin
                next_inst = make_inst();
                inst_valid <= 1'b1;
                inst_word  <= next_inst;
                // latency counts from the edge that presents it
                model_issue(next_inst, cycle);
                issued++;
            end else begin
                inst_valid <= 1'b0;
                inst_word  <= inst_t'($urandom());
            end
        end
        if (issued < NUM_INSTS) begin
            other_errors++;
            $display("stimulus stopped after %0d cycles with %0d instructions issued",
                     cycle, issued);
        end

        // drain the pipeline
        waited = 0;
        while ((expect_q.size() > 0) && (waited < DRAIN_TIMEOUT)) begin
            @(posedge clk);
            cycle++;
            check_retire(cycle);
            inst_valid <= 1'b0;
            waited++;
        end
        if (expect_q.size() > 0) begin
            other_errors++;
            $display("timeout: %0d instructions never retired", expect_q.size());
        end
        // a few quiet cycles to catch extra retires
        repeat (4) begin
            @(posedge clk);
            cycle++;
            check_retire(cycle);
            inst_valid <= 1'b0;
        end
        assert (retired == issued) else begin
            other_errors++;
            $display("retired %0d instructions but issued %0d", retired, issued);
        end

        $display("errors: value %0d, latency %0d, other %0d (issued %0d, retired %0d)",
                 value_errors, latency_errors, other_errors, issued, retired);
        if ((value_errors + latency_errors + other_errors) == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* sources.f */
+incdir+verif
hdl/rv_core_pkg.sv
hdl/rv_regfile.sv
hdl/rv_decode.sv
hdl/rv_execute.sv
hdl/rv_result.sv
hdl/rv_alu_core.sv
verif/tb_rv_alu_core.sv

/* run_sim.sh */
#!/usr/bin/env bash
# build with verilator, run, and pass only if the pass line shows up
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module tb_rv_alu_core \
    -f sources.f -o sim_tb || exit 1

out="$(./obj_dir/sim_tb)"
echo "$out"
echo "$out" | grep -q "^TEST OK$" && echo "simulation passed" && exit 0 \
    || { echo "simulation failed"; exit 1; }
